/* verilog.f */
common/recovery_pkg.sv
design/byte_fifo.sv
design/recovery_receiver/recovery_receiver.sv
design/recovery_executor/recovery_executor.sv
design/recovery_handler.sv
sim/recovery_handler_properties.sv
sim/tb_recovery_handler.sv

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
  --top-module tb_recovery_handler -f verilog.f

out=$(./obj_dir/Vtb_recovery_handler) || true
echo "$out"

if echo "$out" | grep -qx "TEST PASSED"; then
  exit 0
else
  exit 1
fi

/* sim/tb_recovery_handler.sv */
// Random write packets against a byte-level model; bus strobes at most one per cycle, no back-pressure
module tb_recovery_handler;
  timeunit 1ns;
  timeprecision 100ps;

  import recovery_pkg::*;

  localparam int ClkPeriod   = 4;
  localparam int ResetCycles = 8;
  localparam int NumPkts     = 80;
  localparam int WorstCycles = 40;
  localparam int QuietCycles = 40;
  localparam int DoneWait    = 16;
  localparam int WatchdogNs  =
    (NumPkts * (WorstCycles + QuietCycles) + ResetCycles) * ClkPeriod;

  // Packet kinds
  localparam int KindGood    = 0;
  localparam int KindBadPec  = 1;
  localparam int KindUnknown = 2;
  localparam int KindBadLen  = 3;
  localparam int KindStop    = 4;
  localparam int KindRead    = 5;
  localparam int KindMode    = 6;
  localparam int NumKinds    = 7;

  logic             clk_i;
  logic             rst_n_i;
  logic             recovery_mode_i;
  logic             bus_start_i;
  logic             bus_stop_i;
  logic             addr_valid_i;
  logic [ByteW-1:0] addr_i;
  logic             rx_valid_i;
  logic [ByteW-1:0] rx_data_i;
  rec_regs_t        rec_regs_o;
  logic             exec_done_o;
  logic             cmd_error_o;

  int               seed;
  rec_regs_t        model_regs;
  logic [ByteW-1:0] frame [$];

  recovery_handler recovery_handler_i (
    .clk_i,
    .rst_n_i,
    .recovery_mode_i,
    .bus_start_i,
    .bus_stop_i,
    .addr_valid_i,
    .addr_i,
    .rx_valid_i,
    .rx_data_i,
    .rec_regs_o,
    .exec_done_o,
    .cmd_error_o
  );

  bind recovery_handler recovery_handler_properties props_i (
    .clk_i,
    .rst_n_i,
    .push_i      (push),
    .fifo_full_i (fifo_full),
    .exec_done_i (exec_done_o),
    .cmd_error_i (cmd_error_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #(ClkPeriod / 2) clk_i = ~clk_i;
  end

  initial begin
    #(WatchdogNs);
    $display("Watchdog expired before all packets were checked");
    $display("TEST FAILED");
    $fatal(1, "watchdog timeout");
  end

  function automatic int roll(input int n);
    int r;
    r = $random(seed);
    return (r & 32'h7fff_ffff) % n;
  endfunction

  function automatic logic [ByteW-1:0] known_cmd(input int sel);
    case (sel)
      0:       return CMD_DEVICE_RESET;
      1:       return CMD_RECOVERY_CTRL;
      2:       return CMD_INDIRECT_CTRL;
      default: return CMD_INDIRECT_DATA;
    endcase
  endfunction

  function automatic logic [ByteW-1:0] unknown_cmd();
    logic [ByteW-1:0] c;
    c = 8'(roll(256));
    while (c inside {CMD_DEVICE_RESET, CMD_RECOVERY_CTRL, CMD_INDIRECT_CTRL,
                     CMD_INDIRECT_DATA}) begin
      c = 8'(roll(256));
    end
    return c;
  endfunction

  // Payload byte k lands in bits 8k+7:8k, upper bytes untouched
  function automatic void model_write(input logic [ByteW-1:0] cmd, input int len);
    logic [RegW-1:0] word;
    case (cmd)
      CMD_DEVICE_RESET:  word = model_regs.device_reset;
      CMD_RECOVERY_CTRL: word = model_regs.recovery_ctrl;
      CMD_INDIRECT_CTRL: word = model_regs.indirect_ctrl;
      default:           word = model_regs.indirect_data;
    endcase
    for (int k = 0; k < len; k++) begin
      word[8*k +: 8] = frame[3 + k];
    end
    case (cmd)
      CMD_DEVICE_RESET:  model_regs.device_reset  = word;
      CMD_RECOVERY_CTRL: model_regs.recovery_ctrl = word;
      CMD_INDIRECT_CTRL: model_regs.indirect_ctrl = word;
      default:           model_regs.indirect_data = word;
    endcase
  endfunction

  task automatic compare_value(input string name, input logic [$bits(rec_regs_t)-1:0] got,
                               input logic [$bits(rec_regs_t)-1:0] exp);
    if (got !== exp) begin
      $display("FAIL %s got 0x%0h expected 0x%0h", name, got, exp);
      $display("TEST FAILED");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  task automatic step_clock();
    @(posedge clk_i);
    #1;
  endtask

  task automatic idle_gap();
    repeat (roll(2)) step_clock();
  endtask

  task automatic pulse_start();
    bus_start_i = 1'b1;
    step_clock();
    bus_start_i = 1'b0;
  endtask

  task automatic pulse_stop();
    bus_stop_i = 1'b1;
    step_clock();
    bus_stop_i = 1'b0;
  endtask

  task automatic strobe_addr(input logic [ByteW-1:0] a);
    addr_valid_i = 1'b1;
    addr_i       = a;
    step_clock();
    addr_valid_i = 1'b0;
  endtask

  task automatic put_byte(input logic [ByteW-1:0] b);
    rx_valid_i = 1'b1;
    rx_data_i  = b;
    step_clock();
    rx_valid_i = 1'b0;
  endtask

  // Sampled mid-cycle, registers settle with the done pulse
  task automatic await_done(input logic exp_err);
    int n;
    n = 0;
    @(negedge clk_i);
    while (exec_done_o !== 1'b1 && n < DoneWait) begin
      @(negedge clk_i);
      n++;
    end
    if (exec_done_o !== 1'b1) begin
      $display("No exec_done_o pulse within %0d cycles after the packet", DoneWait);
      $display("TEST FAILED");
      $fatal(1, "timeout waiting for exec_done_o");
    end
    compare_value("cmd_error_o", cmd_error_o, exp_err);
    compare_value("rec_regs_o", rec_regs_o, model_regs);
    step_clock();
  endtask

  task automatic expect_quiet(input int cycles);
    repeat (cycles) begin
      @(negedge clk_i);
      compare_value("exec_done_o", exec_done_o, '0);
    end
    compare_value("rec_regs_o", rec_regs_o, model_regs);
    step_clock();
  endtask

  task automatic run_packet(input int kind);
    logic [ByteW-1:0] addr;
    logic [ByteW-1:0] cmd;
    logic [ByteW-1:0] pec;
    int               len;
    int               nsend;
    addr = {7'(roll(128)), 1'b0};
    cmd  = known_cmd(roll(4));
    len  = 1 + roll(RegBytes);
    if (kind == KindUnknown) begin
      cmd = unknown_cmd();
    end
    if (kind == KindBadLen) begin
      len = (roll(2) == 0) ? 0 : RegBytes + 1;
    end
    if (kind == KindRead) begin
      addr[0] = 1'b1;
    end
    frame.delete();
    frame.push_back(cmd);
    frame.push_back(8'(len));
    frame.push_back(8'h00);
    for (int i = 0; i < len; i++) begin
      frame.push_back(8'(roll(256)));
    end
    // PEC over address and every byte before it
    pec = pec_step('0, addr);
    foreach (frame[i]) begin
      pec = pec_step(pec, frame[i]);
    end
    if (kind == KindBadPec) begin
      pec = pec ^ 8'(1 + roll(255));
    end
    frame.push_back(pec);
    nsend = frame.size();
    if (kind == KindStop) begin
      nsend = 3 + roll(len + 1);
    end
    if (kind == KindGood) begin
      model_write(cmd, len);
    end
    if (kind == KindMode) begin
      recovery_mode_i = 1'b0;
    end
    pulse_start();
    idle_gap();
    strobe_addr(addr);
    for (int i = 0; i < nsend; i++) begin
      idle_gap();
      put_byte(frame[i]);
    end
    case (kind)
      KindStop: begin
        pulse_stop();
        await_done(1'b1);
      end
      KindRead, KindMode: begin
        pulse_stop();
        expect_quiet(QuietCycles);
        recovery_mode_i = 1'b1;
      end
      default: begin
        await_done(kind != KindGood);
        pulse_stop();
      end
    endcase
  endtask

  initial begin
    int   kind;
    logic force_good;
    seed            = 34;
    model_regs      = '0;
    rst_n_i         = 1'b0;
    recovery_mode_i = 1'b1;
    bus_start_i     = 1'b0;
    bus_stop_i      = 1'b0;
    addr_valid_i    = 1'b0;
    addr_i          = '0;
    rx_valid_i      = 1'b0;
    rx_data_i       = '0;
    force_good      = 1'b0;
    repeat (ResetCycles) @(posedge clk_i);
    #1;
    rst_n_i = 1'b1;
    compare_value("rec_regs_o", rec_regs_o, model_regs);
    compare_value("exec_done_o", exec_done_o, '0);
    for (int p = 0; p < NumPkts; p++) begin
      // Every kind once, then a random mix
      if (p < NumKinds) begin
        kind = p;
      end else if (force_good) begin
        kind = KindGood;
      end else begin
        kind = roll(10);
        if (kind >= NumKinds) begin
          kind = KindGood;
        end
      end
      // A truncated packet is followed by a good one to prove the FIFO drained
      force_good = (kind == KindStop);
      run_packet(kind);
    end
    $display("TEST PASSED");
    $finish;
  end

endmodule

/* sim/recovery_handler_properties.sv */
// Bound into recovery_handler; checks hold only while reset is released
module recovery_handler_properties (
  input logic clk_i,
  input logic rst_n_i,
  input logic push_i,
  input logic fifo_full_i,
  input logic exec_done_i,
  input logic cmd_error_i
);
  timeunit 1ns;
  timeprecision 100ps;

  // Error is a qualifier of done
  error_needs_done: assert property (
    @(posedge clk_i) disable iff (!rst_n_i) cmd_error_i |-> exec_done_i
  ) else $error("cmd_error_o asserted without exec_done_o");

  // Room for two payloads, so no push may leave the FIFO full
  no_fill_on_push: assert property (
    @(posedge clk_i) disable iff (!rst_n_i) push_i |=> !fifo_full_i
  ) else $error("push left the FIFO full");

  // One done per packet
  done_single_pulse: assert property (
    @(posedge clk_i) disable iff (!rst_n_i) exec_done_i |=> !exec_done_i
  ) else $error("exec_done_o high in two consecutive cycles");

endmodule

/* design/recovery_handler.sv */
// Write path only; bus strobes carry no back-pressure and must come at most one per cycle
module recovery_handler (
  input  logic                           clk_i,
  input  logic                           rst_n_i,
  input  logic                           recovery_mode_i,
  input  logic                           bus_start_i,
  input  logic                           bus_stop_i,
  input  logic                           addr_valid_i,
  input  logic [recovery_pkg::ByteW-1:0] addr_i,
  input  logic                           rx_valid_i,
  input  logic [recovery_pkg::ByteW-1:0] rx_data_i,
  output recovery_pkg::rec_regs_t        rec_regs_o,
  output logic                           exec_done_o,
  output logic                           cmd_error_o
);
  import recovery_pkg::*;

  logic             push;
  logic [ByteW-1:0] push_data;
  logic             fifo_full;
  logic             pop;
  logic [ByteW-1:0] pop_data;
  logic             fifo_empty;
  logic             desc_valid;
  pkt_desc_t        desc;

  recovery_receiver xrecovery_receiver (
    .clk_i,
    .rst_n_i,
    .recovery_mode_i,
    .bus_start_i,
    .bus_stop_i,
    .addr_valid_i,
    .addr_i,
    .rx_valid_i,
    .rx_data_i,
    .fifo_full_i (fifo_full),
    .push_o      (push),
    .push_data_o (push_data),
    .desc_valid_o(desc_valid),
    .desc_o      (desc)
  );

  byte_fifo xbyte_fifo (
    .clk_i,
    .rst_n_i,
    .push_i     (push),
    .push_data_i(push_data),
    .full_o     (fifo_full),
    .pop_i      (pop),
    .pop_data_o (pop_data),
    .empty_o    (fifo_empty)
  );

  recovery_executor xrecovery_executor (
    .clk_i,
    .rst_n_i,
    .desc_valid_i(desc_valid),
    .desc_i      (desc),
    .fifo_empty_i(fifo_empty),
    .pop_data_i  (pop_data),
    .pop_o       (pop),
    .regs_o      (rec_regs_o),
    .done_o      (exec_done_o),
    .error_o     (cmd_error_o)
  );

endmodule

/* design/recovery_executor/recovery_executor.sv */
// Descriptor bytes must already be buffered; a descriptor arriving while draining is dropped
module recovery_executor (
  input  logic                           clk_i,
  input  logic                           rst_n_i,
  input  logic                           desc_valid_i,
  input  recovery_pkg::pkt_desc_t        desc_i,
  input  logic                           fifo_empty_i,
  input  logic [recovery_pkg::ByteW-1:0] pop_data_i,
  output logic                           pop_o,
  output recovery_pkg::rec_regs_t        regs_o,
  output logic                           done_o,
  output logic                           error_o
);
  import recovery_pkg::*;

  ex_state_e                    state_q;
  logic [NumRegs-1:0][RegW-1:0] reg_q;
  logic [$clog2(NumRegs)-1:0]   idx_d;
  logic [$clog2(NumRegs)-1:0]   idx_q;
  logic                         known_d;
  logic                         accept_d;
  logic                         wr_en_q;
  logic                         err_q;
  logic [LenW-1:0]              remain_q;
  logic [LenW-1:0]              lane_q;

  // Index 3 is the top word of rec_regs_t
  always_comb begin
    known_d = 1'b1;
    case (rec_cmd_e'(desc_i.cmd))
      CMD_DEVICE_RESET:  idx_d = 2'd3;
      CMD_RECOVERY_CTRL: idx_d = 2'd2;
      CMD_INDIRECT_CTRL: idx_d = 2'd1;
      CMD_INDIRECT_DATA: idx_d = 2'd0;
      default: begin
        idx_d   = '0;
        known_d = 1'b0;
      end
    endcase
  end

  assign accept_d = desc_i.ok & known_d;
  assign pop_o    = (state_q == EX_DRAIN) & ~fifo_empty_i;
  assign regs_o   = rec_regs_t'(reg_q);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q  <= EX_IDLE;
      idx_q    <= '0;
      wr_en_q  <= 1'b0;
      err_q    <= 1'b0;
      remain_q <= '0;
      lane_q   <= '0;
      done_o   <= 1'b0;
      error_o  <= 1'b0;
    end else begin
      done_o  <= 1'b0;
      error_o <= 1'b0;
      case (state_q)
        EX_IDLE: begin
          if (desc_valid_i) begin
            idx_q    <= idx_d;
            wr_en_q  <= accept_d;
            err_q    <= ~accept_d;
            remain_q <= desc_i.count;
            lane_q   <= '0;
            if (desc_i.count == '0) begin
              done_o  <= 1'b1;
              error_o <= ~accept_d;
            end else begin
              state_q <= EX_DRAIN;
            end
          end
        end
        EX_DRAIN: begin
          if (pop_o) begin
            lane_q   <= lane_q + 1'b1;
            remain_q <= remain_q - 1'b1;
            // Last byte popped
            if (remain_q == LenW'(1)) begin
              state_q <= EX_IDLE;
              done_o  <= 1'b1;
              error_o <= err_q;
            end
          end
        end
        default: state_q <= EX_IDLE;
      endcase
    end
  end

  // Bytes above the length keep their value
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      reg_q <= '0;
    end else if (pop_o && wr_en_q && lane_q < LenW'(RegBytes)) begin
      reg_q[idx_q][lane_q*ByteW +: ByteW] <= pop_data_i;
    end
  end

endmodule

/* design/recovery_receiver/recovery_receiver.sv */
// Assumes at most one byte per cycle; payload of an illegal length is parsed but never buffered
module recovery_receiver (
  input  logic                           clk_i,
  input  logic                           rst_n_i,
  input  logic                           recovery_mode_i,
  input  logic                           bus_start_i,
  input  logic                           bus_stop_i,
  input  logic                           addr_valid_i,
  input  logic [recovery_pkg::ByteW-1:0] addr_i,
  input  logic                           rx_valid_i,
  input  logic [recovery_pkg::ByteW-1:0] rx_data_i,
  input  logic                           fifo_full_i,
  output logic                           push_o,
  output logic [recovery_pkg::ByteW-1:0] push_data_o,
  output logic                           desc_valid_o,
  output recovery_pkg::pkt_desc_t        desc_o
);
  import recovery_pkg::*;

  rx_state_e          state_q;
  logic [ByteW-1:0]   pec_q;
  logic [ByteW-1:0]   len_lo_q;
  logic [2*ByteW-1:0] remain_q;
  logic               len_ok_q;
  logic [LenW-1:0]    cnt_q;
  logic               drop_q;
  logic               cand_q;
  logic [ByteW-1:0]   cmd_q;

  logic               abort;
  logic               cmd_seen;
  logic [2*ByteW-1:0] len_full;
  logic [LenW-1:0]    cnt_now;
  logic               drop_now;
  logic               desc_fire;
  logic               desc_ok;

  // Start, stop or leaving recovery mode ends the packet
  assign abort    = bus_start_i | bus_stop_i | ~recovery_mode_i;
  assign cmd_seen = state_q inside {RX_LEN_LO, RX_LEN_HI, RX_DATA, RX_PEC};
  assign len_full = {rx_data_i, len_lo_q};

  // Byte registered last cycle goes out now unless the buffer is full
  assign push_o   = cand_q & ~fifo_full_i;
  assign cnt_now  = cnt_q + LenW'(push_o);
  assign drop_now = drop_q | (cand_q & fifo_full_i);

  assign desc_fire = abort ? cmd_seen : (rx_valid_i && state_q == RX_PEC);
  assign desc_ok   = ~abort & (rx_data_i == pec_q) & len_ok_q & ~drop_now;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q      <= RX_IDLE;
      pec_q        <= '0;
      remain_q     <= '0;
      len_ok_q     <= 1'b0;
      cnt_q        <= '0;
      drop_q       <= 1'b0;
      cand_q       <= 1'b0;
      desc_valid_o <= 1'b0;
    end else begin
      cnt_q        <= cnt_now;
      drop_q       <= drop_now;
      desc_valid_o <= desc_fire;
      cand_q       <= ~abort & rx_valid_i & (state_q == RX_DATA) & len_ok_q;
      if (abort) begin
        state_q <= RX_IDLE;
      end else begin
        case (state_q)
          RX_IDLE: begin
            if (addr_valid_i) begin
              // Address byte seeds the PEC, bit 0 high means a read
              pec_q   <= pec_step('0, addr_i);
              cnt_q   <= '0;
              drop_q  <= 1'b0;
              state_q <= addr_i[0] ? RX_SKIP : RX_CMD;
            end
          end
          RX_CMD: begin
            if (rx_valid_i) begin
              pec_q   <= pec_step(pec_q, rx_data_i);
              state_q <= RX_LEN_LO;
            end
          end
          RX_LEN_LO: begin
            if (rx_valid_i) begin
              pec_q   <= pec_step(pec_q, rx_data_i);
              state_q <= RX_LEN_HI;
            end
          end
          RX_LEN_HI: begin
            if (rx_valid_i) begin
              pec_q    <= pec_step(pec_q, rx_data_i);
              remain_q <= len_full;
              len_ok_q <= (len_full != '0) && (len_full <= (2*ByteW)'(RegBytes));
              state_q  <= (len_full == '0) ? RX_PEC : RX_DATA;
            end
          end
          RX_DATA: begin
            if (rx_valid_i) begin
              pec_q    <= pec_step(pec_q, rx_data_i);
              remain_q <= remain_q - 1'b1;
              if (remain_q == (2*ByteW)'(1)) begin
                state_q <= RX_PEC;
              end
            end
          end
          RX_PEC: begin
            if (rx_valid_i) begin
              state_q <= RX_SKIP;
            end
          end
          // Wait here for the next start
          RX_SKIP: state_q <= RX_SKIP;
          default: state_q <= RX_IDLE;
        endcase
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rx_valid_i) begin
      push_data_o <= rx_data_i;
    end
    if (rx_valid_i && state_q == RX_CMD) begin
      cmd_q <= rx_data_i;
    end
    if (rx_valid_i && state_q == RX_LEN_LO) begin
      len_lo_q <= rx_data_i;
    end
    if (desc_fire) begin
      desc_o <= '{cmd: cmd_q, count: cnt_now, ok: desc_ok};
    end
  end

endmodule

/* design/byte_fifo.sv */
// Depth must be a power of two; pushes when full and pops when empty are ignored
module byte_fifo (
  input  logic                           clk_i,
  input  logic                           rst_n_i,
  input  logic                           push_i,
  input  logic [recovery_pkg::ByteW-1:0] push_data_i,
  output logic                           full_o,
  input  logic                           pop_i,
  output logic [recovery_pkg::ByteW-1:0] pop_data_o,
  output logic                           empty_o
);
  import recovery_pkg::*;

  logic [ByteW-1:0]  mem_q [FifoDepth];
  logic [FifoAw-1:0] wr_ptr_q;
  logic [FifoAw-1:0] rd_ptr_q;
  logic [FifoAw:0]   count_q;

  logic              wr_en;
  logic              rd_en;

  assign full_o  = count_q == (FifoAw+1)'(FifoDepth);
  assign empty_o = count_q == '0;
  assign wr_en   = push_i & ~full_o;
  assign rd_en   = pop_i & ~empty_o;

  // Head entry, no read latency
  assign pop_data_o = mem_q[rd_ptr_q];

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (rd_en) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      case ({wr_en, rd_en})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_en) begin
      mem_q[wr_ptr_q] <= push_data_i;
    end
  end

endmodule

/* common/recovery_pkg.sv */
// PEC is CRC-8 (poly 0x07, zero init); command codes outside rec_cmd_e are treated as unknown
package recovery_pkg;

  // Bus and register geometry
  localparam int unsigned ByteW     = 8;
  localparam int unsigned RegBytes  = 4;
  localparam int unsigned RegW      = RegBytes * ByteW;
  localparam int unsigned LenW      = 3;
  localparam int unsigned NumRegs   = 4;

  // Payload buffer, two maximum payloads deep
  localparam int unsigned FifoDepth = 8;
  localparam int unsigned FifoAw    = 3;

  localparam logic [ByteW-1:0] PecPoly = 8'h07;

  // Writable recovery commands
  typedef enum logic [7:0] {
    CMD_DEVICE_RESET  = 8'h25,
    CMD_RECOVERY_CTRL = 8'h26,
    CMD_INDIRECT_CTRL = 8'h29,
    CMD_INDIRECT_DATA = 8'h2B
  } rec_cmd_e;

  typedef enum logic [2:0] {
    RX_IDLE,
    RX_CMD,
    RX_LEN_LO,
    RX_LEN_HI,
    RX_DATA,
    RX_PEC,
    RX_SKIP
  } rx_state_e;

  typedef enum logic {
    EX_IDLE,
    EX_DRAIN
  } ex_state_e;

  // One per packet from the receiver
  typedef struct packed {
    logic [ByteW-1:0] cmd;
    logic [LenW-1:0]  count;
    logic             ok;
  } pkt_desc_t;

  // Writable recovery registers, device_reset in the top word
  typedef struct packed {
    logic [RegW-1:0] device_reset;
    logic [RegW-1:0] recovery_ctrl;
    logic [RegW-1:0] indirect_ctrl;
    logic [RegW-1:0] indirect_data;
  } rec_regs_t;

  // One byte of CRC-8, MSB first
  function automatic logic [ByteW-1:0] pec_step(input logic [ByteW-1:0] crc,
                                                input logic [ByteW-1:0] data);
    logic [ByteW-1:0] c;
    c = crc ^ data;
    for (int i = 0; i < ByteW; i++) begin
      if (c[ByteW-1]) begin
        c = (c << 1) ^ PecPoly;
      end else begin
        c = c << 1;
      end
    end
    return c;
  endfunction

endpackage
